/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_soc -f files.f --Mdir obj_dir -o tb_soc

run: compile
	./obj_dir/tb_soc | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bus_req_if.sv */
`include "soc_defs.svh"

interface bus_req_if import soc_pkg::*; ();

  logic                   valid;
  logic                   ready;
  logic                   we;
  target_e                target;
  logic [8:0]             index;
  logic [`SOC_DATA_W-1:0] wdata;
  logic [`SOC_STRB_W-1:0] strb;

  modport source (
    output valid, we, target, index, wdata, strb,
    input  ready
  );

  modport sink (
    input  valid, we, target, index, wdata, strb,
    output ready
  );

endinterface

/* files.f */
+incdir+.
soc_pkg.sv
bus_req_if.sv
soc_l2_mem.sv
soc_addr_decoder.sv
soc_req_fifo.sv
soc_target_unit.sv
soc_top.sv
tb_soc.sv

/* soc_addr_decoder.sv */
`include "soc_defs.svh"

module soc_addr_decoder import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  logic                   req_we_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  input  logic [`SOC_STRB_W-1:0] req_strb_i,
  output logic                   req_ready_o,
  bus_req_if.source              req_o
);

  soc_addr_u              addr;
  logic                   in_l2;
  logic                   in_ctrl;
  target_e                tgt_d;
  logic [8:0]             idx_d;
  logic                   valid_q;
  logic                   we_q;
  target_e                tgt_q;
  logic [8:0]             idx_q;
  logic [`SOC_DATA_W-1:0] wdata_q;
  logic [`SOC_STRB_W-1:0] strb_q;

  assign addr    = req_addr_i;
  assign in_l2   = (req_addr_i >= `SOC_DRAM_BASE) &&
                   (req_addr_i < `SOC_DRAM_BASE + `SOC_DRAM_LEN);
  assign in_ctrl = (req_addr_i >= `SOC_CTRL_BASE) &&
                   (req_addr_i < `SOC_CTRL_BASE + `SOC_CTRL_LEN);

  always_comb begin
    tgt_d = TGT_NONE;
    idx_d = '0;
    if (in_l2) begin
      tgt_d = TGT_L2;
      idx_d = {1'b0, addr.mem.word};
    end else if (in_ctrl) begin
      tgt_d = TGT_CTRL;
      idx_d = addr.ctrl.reg_idx;
    end
  end

  // Stage frees up when empty or draining
  assign req_ready_o = !valid_q || req_o.ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      we_q    <= req_we_i;
      tgt_q   <= tgt_d;
      idx_q   <= idx_d;
      wdata_q <= req_wdata_i;
      strb_q  <= req_strb_i;
    end
  end

  assign req_o.valid  = valid_q;
  assign req_o.we     = we_q;
  assign req_o.target = tgt_q;
  assign req_o.index  = idx_q;
  assign req_o.wdata  = wdata_q;
  assign req_o.strb   = strb_q;

endmodule

/* soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W 8

// L2 depth in 64-bit words
`define SOC_L2_WORDS 256

//////////////////////////////////////////////////////////////////////
// Memory map
//////////////////////////////////////////////////////////////////////

`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LEN  32'h800
`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LEN  32'h1000

// Control register indices
`define SOC_REG_EXIT    0
`define SOC_REG_CNT_EN  1
`define SOC_REG_SCRATCH 2

`endif

/* soc_l2_mem.sv */
`include "soc_defs.svh"

module soc_l2_mem (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [7:0]             index_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  input  logic [`SOC_STRB_W-1:0] strb_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_L2_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Byte lanes with strobe set
        for (int b = 0; b < `SOC_STRB_W; b++) begin
          if (strb_i[b]) begin
            mem_q[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[index_i];
      end
    end
  end

endmodule

/* soc_pkg.sv */
`include "soc_defs.svh"

package soc_pkg;

  // Decoded destination of a request
  typedef enum logic [1:0] {
    TGT_L2,
    TGT_CTRL,
    TGT_NONE
  } target_e;

  // One address word, seen as a memory or a register address
  typedef union packed {
    struct packed {
      logic [20:0] upper;
      logic [7:0]  word;
      logic [2:0]  offset;
    } mem;
    struct packed {
      logic [19:0] upper;
      logic [8:0]  reg_idx;
      logic [2:0]  offset;
    } ctrl;
  } soc_addr_u;

  // Response word
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } soc_rsp_t;

endpackage

/* soc_req_fifo.sv */
`include "soc_defs.svh"

module soc_req_fifo import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  bus_req_if.sink   in_i,
  bus_req_if.source out_o
);

  logic                   wr_ptr_q;
  logic                   rd_ptr_q;
  logic [1:0]             count_q;
  logic                   push;
  logic                   pop;
  logic                   we_q    [2];
  target_e                tgt_q   [2];
  logic [8:0]             idx_q   [2];
  logic [`SOC_DATA_W-1:0] wdata_q [2];
  logic [`SOC_STRB_W-1:0] strb_q  [2];

  // Full queue still takes a push when the head leaves
  assign in_i.ready = (count_q != 2'd2) || out_o.ready;
  assign push       = in_i.valid && in_i.ready;
  assign pop        = out_o.valid && out_o.ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      if (push && !pop) begin
        count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      we_q[wr_ptr_q]    <= in_i.we;
      tgt_q[wr_ptr_q]   <= in_i.target;
      idx_q[wr_ptr_q]   <= in_i.index;
      wdata_q[wr_ptr_q] <= in_i.wdata;
      strb_q[wr_ptr_q]  <= in_i.strb;
    end
  end

  // Head of queue
  assign out_o.valid  = count_q != '0;
  assign out_o.we     = we_q[rd_ptr_q];
  assign out_o.target = tgt_q[rd_ptr_q];
  assign out_o.index  = idx_q[rd_ptr_q];
  assign out_o.wdata  = wdata_q[rd_ptr_q];
  assign out_o.strb   = strb_q[rd_ptr_q];

endmodule

/* soc_target_unit.sv */
`include "soc_defs.svh"

module soc_target_unit import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  bus_req_if.sink                req_i,
  output logic                   rsp_valid_o,
  output soc_rsp_t               rsp_o,
  input  logic                   rsp_ready_i,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o
);

  logic                   accept;
  logic                   l2_acc;
  logic                   ctrl_wr;
  logic                   reg_hit;
  logic                   req_err;
  logic                   pend_q;
  logic                   pend_we_q;
  logic                   rsp_valid_q;
  soc_rsp_t               rsp_q;
  logic [`SOC_DATA_W-1:0] reg_rdata;
  logic [`SOC_DATA_W-1:0] l2_rdata;
  logic [`SOC_DATA_W-1:0] exit_q;
  logic [`SOC_DATA_W-1:0] cnt_en_q;
  logic [`SOC_DATA_W-1:0] scratch_q;

  function automatic logic [`SOC_DATA_W-1:0] strb_merge(
    input logic [`SOC_DATA_W-1:0] old_data,
    input logic [`SOC_DATA_W-1:0] new_data,
    input logic [`SOC_STRB_W-1:0] strb
  );
    logic [`SOC_DATA_W-1:0] res;
    res = old_data;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // One request at a time, nothing while a response waits
  assign req_i.ready = !pend_q && (!rsp_valid_q || rsp_ready_i);
  assign accept      = req_i.valid && req_i.ready;
  assign l2_acc      = accept && (req_i.target == TGT_L2);
  assign req_err     = (req_i.target == TGT_NONE) || ((req_i.target == TGT_CTRL) && !reg_hit);
  assign ctrl_wr     = accept && (req_i.target == TGT_CTRL) && req_i.we && reg_hit;

  //////////////////////////////////////////////////////////////////////
  // L2 memory
  //////////////////////////////////////////////////////////////////////

  soc_l2_mem i_l2_mem (
    .clk_i  (clk_i             ),
    .req_i  (l2_acc            ),
    .we_i   (req_i.we          ),
    .index_i(req_i.index[7:0]  ),
    .wdata_i(req_i.wdata       ),
    .strb_i (req_i.strb        ),
    .rdata_o(l2_rdata          )
  );

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    reg_rdata = '0;
    reg_hit   = 1'b1;
    case (req_i.index)
      `SOC_REG_EXIT:    reg_rdata = exit_q;
      `SOC_REG_CNT_EN:  reg_rdata = cnt_en_q;
      `SOC_REG_SCRATCH: reg_rdata = scratch_q;
      default:          reg_hit   = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_q      <= '0;
      cnt_en_q    <= '0;
      scratch_q   <= '0;
      pend_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      pend_q <= l2_acc;
      if (rsp_valid_q && rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      // Registers answer next cycle, L2 one cycle later
      if ((accept && !l2_acc) || pend_q) begin
        rsp_valid_q <= 1'b1;
      end
      if (ctrl_wr) begin
        case (req_i.index)
          `SOC_REG_EXIT:   exit_q   <= strb_merge(exit_q, req_i.wdata, req_i.strb);
          `SOC_REG_CNT_EN: cnt_en_q <= strb_merge(cnt_en_q, req_i.wdata, req_i.strb);
          default:         scratch_q <= strb_merge(scratch_q, req_i.wdata, req_i.strb);
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (l2_acc) begin
      pend_we_q <= req_i.we;
    end
    if (accept && !l2_acc) begin
      rsp_q.rdata <= (req_err || req_i.we) ? '0 : reg_rdata;
      rsp_q.err   <= req_err;
    end else if (pend_q) begin
      rsp_q.rdata <= pend_we_q ? '0 : l2_rdata;
      rsp_q.err   <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

/* soc_top.sv */
`include "soc_defs.svh"

module soc_top import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Request channel
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_we_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  input  logic [`SOC_STRB_W-1:0] req_strb_i,
  // Response channel
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`SOC_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o
);

  soc_rsp_t rsp;

  bus_req_if dec_req ();
  bus_req_if q_req ();

  //////////////////////////////////////////////////////////////////////
  // Decode, queue, execute
  //////////////////////////////////////////////////////////////////////

  soc_addr_decoder i_addr_decoder (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_valid_i(req_valid_i),
    .req_we_i   (req_we_i   ),
    .req_addr_i (req_addr_i ),
    .req_wdata_i(req_wdata_i),
    .req_strb_i (req_strb_i ),
    .req_ready_o(req_ready_o),
    .req_o      (dec_req    )
  );

  soc_req_fifo i_req_fifo (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .in_i   (dec_req),
    .out_o  (q_req  )
  );

  soc_target_unit i_target_unit (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (q_req      ),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp        ),
    .rsp_ready_i(rsp_ready_i),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

  assign rsp_rdata_o = rsp.rdata;
  assign rsp_err_o   = rsp.err;

endmodule

/* tb_soc.sv */
`include "soc_defs.svh"

module tb_soc;

  localparam int NUM_DIRECTED  = 26;
  localparam int NUM_RANDOM    = 200;
  localparam int WATCHDOG_TIME = (NUM_DIRECTED + NUM_RANDOM) * 40 * 4 + 10 * 4;
  localparam logic [31:0] L2  = `SOC_DRAM_BASE;
  localparam logic [31:0] REG = `SOC_CTRL_BASE;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  logic                   req_ready;
  logic                   req_we;
  logic [`SOC_ADDR_W-1:0] req_addr;
  logic [`SOC_DATA_W-1:0] req_wdata;
  logic [`SOC_STRB_W-1:0] req_strb;
  logic                   rsp_valid;
  logic                   rsp_ready;
  logic [`SOC_DATA_W-1:0] rsp_rdata;
  logic                   rsp_err;
  logic [`SOC_DATA_W-1:0] exit_w;
  logic [`SOC_DATA_W-1:0] cnt_en_w;

  logic                   stall_en;
  int                     chk_errors = 0;
  int                     rsp_errors = 0;
  string                  test_name;
  logic [`SOC_DATA_W:0]   exp_q [$];
  string                  name_q [$];
  logic [`SOC_DATA_W:0]   exp_rsp;
  string                  exp_name;

  // Model of L2 and the control registers
  logic [`SOC_DATA_W-1:0] mem_m [`SOC_L2_WORDS];
  logic [`SOC_DATA_W-1:0] regs_m [3] = '{default: '0};
  logic                   l2_written [`SOC_L2_WORDS] = '{default: 1'b0};

  soc_top u_dut (
    .clk_i      (clk      ),
    .rst_n_i    (rst_n    ),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .req_we_i   (req_we   ),
    .req_addr_i (req_addr ),
    .req_wdata_i(req_wdata),
    .req_strb_i (req_strb ),
    .rsp_valid_o(rsp_valid),
    .rsp_ready_i(rsp_ready),
    .rsp_rdata_o(rsp_rdata),
    .rsp_err_o  (rsp_err  ),
    .exit_o     (exit_w   ),
    .hw_cnt_en_o(cnt_en_w )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired with %0d responses still missing", exp_q.size());
    $display("STATUS: FAIL");
    $finish;
  end

  // Random stalls on the response side
  initial begin
    rsp_ready = 1'b0;
    forever begin
      @(negedge clk);
      rsp_ready = stall_en ? (($urandom % 3) == 0) : 1'b1;
    end
  end

  function automatic logic [`SOC_DATA_W-1:0] apply_strobe(
    input logic [`SOC_DATA_W-1:0] old_word,
    input logic [`SOC_DATA_W-1:0] new_word,
    input logic [`SOC_STRB_W-1:0] strb
  );
    logic [`SOC_DATA_W-1:0] mask;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Expected {rdata, err} of one request
  // Model state advances in request order
  function automatic logic [`SOC_DATA_W:0] predict_rsp(
    input logic                   we,
    input logic [`SOC_ADDR_W-1:0] addr,
    input logic [`SOC_DATA_W-1:0] wdata,
    input logic [`SOC_STRB_W-1:0] strb
  );
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
    int                     idx;
    rdata = '0;
    err   = 1'b0;
    if (addr >= L2 && addr < (L2 + `SOC_DRAM_LEN)) begin
      idx = int'((addr - L2) >> 3);
      if (we) begin
        mem_m[idx] = apply_strobe(mem_m[idx], wdata, strb);
      end else begin
        rdata = mem_m[idx];
      end
    end else if (addr >= REG && addr < (REG + `SOC_CTRL_LEN)) begin
      idx = int'((addr - REG) >> 3);
      if (idx > `SOC_REG_SCRATCH) begin
        err = 1'b1;
      end else if (we) begin
        regs_m[idx] = apply_strobe(regs_m[idx], wdata, strb);
      end else begin
        rdata = regs_m[idx];
      end
    end else begin
      err = 1'b1;
    end
    return {rdata, err};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Response arrived with no request outstanding");
          rsp_errors++;
        end else begin
          exp_rsp  = exp_q.pop_front();
          exp_name = name_q.pop_front();
          if (rsp_err !== exp_rsp[0]) begin
            $display("FAIL %s err expected %0b actual %0b", exp_name, exp_rsp[0], rsp_err);
            rsp_errors++;
          end
          if (rsp_rdata !== exp_rsp[`SOC_DATA_W:1]) begin
            $display("FAIL %s rdata expected %h actual %h", exp_name,
                     exp_rsp[`SOC_DATA_W:1], rsp_rdata);
            rsp_errors++;
          end
        end
      end
      // Accepted request
      if (req_valid && req_ready) begin
        exp_q.push_back(predict_rsp(req_we, req_addr, req_wdata, req_strb));
        name_q.push_back(test_name);
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      chk_errors++;
    end
  endtask

  task automatic send_req(
    input logic                   we,
    input logic [`SOC_ADDR_W-1:0] addr,
    input logic [`SOC_DATA_W-1:0] wdata,
    input logic [`SOC_STRB_W-1:0] strb
  );
    @(negedge clk);
    req_valid = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    req_strb  = strb;
    do begin
      @(posedge clk);
    end while (!req_ready);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_STRB_W-1:0] strb;
    logic [7:0]             word;
    int                     kind;
    void'($urandom(32'h377c));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_we    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_strb  = '0;
    stall_en  = 1'b0;
    test_name = "reset";
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset exit_o", '0, exit_w);
    check_value("reset hw_cnt_en_o", '0, cnt_en_w);
    check_value("reset rsp_valid_o", '0, {63'd0, rsp_valid});
    check_value("reset req_ready_o", 64'd1, {63'd0, req_ready});

    test_name = "l2_write";
    send_req(1'b1, L2 + 32'h000, 64'h0123_4567_89ab_cdef, 8'hff);
    send_req(1'b1, L2 + 32'h008, 64'hfedc_ba98_7654_3210, 8'hff);
    send_req(1'b1, L2 + 32'h010, 64'h5555_aaaa_5555_aaaa, 8'hff);
    send_req(1'b1, L2 + 32'h7f8, 64'h0f0f_0f0f_f0f0_f0f0, 8'hff);
    send_req(1'b1, L2 + 32'h008, 64'h1122_3344_5566_7788, 8'h0f);
    send_req(1'b1, L2 + 32'h010, 64'h99aa_bbcc_ddee_ff00, 8'ha5);
    test_name = "l2_read";
    send_req(1'b0, L2 + 32'h000, '0, 8'hff);
    send_req(1'b0, L2 + 32'h008, '0, 8'hff);
    send_req(1'b0, L2 + 32'h010, '0, 8'hff);
    send_req(1'b0, L2 + 32'h7f8, '0, 8'hff);
    wait_drain();

    test_name = "ctrl_write";
    send_req(1'b1, REG + 32'h00, 64'h0000_0000_0000_002a, 8'hff);
    send_req(1'b1, REG + 32'h08, 64'h0000_0000_0000_0007, 8'hff);
    send_req(1'b1, REG + 32'h10, 64'hdead_beef_cafe_f00d, 8'hff);
    send_req(1'b1, REG + 32'h10, 64'h1111_2222_3333_4444, 8'hc3);
    wait_drain();
    check_value("ctrl_write exit_o", regs_m[`SOC_REG_EXIT], exit_w);
    check_value("ctrl_write hw_cnt_en_o", regs_m[`SOC_REG_CNT_EN], cnt_en_w);
    test_name = "ctrl_read";
    send_req(1'b0, REG + 32'h00, '0, 8'hff);
    send_req(1'b0, REG + 32'h08, '0, 8'hff);
    send_req(1'b0, REG + 32'h10, '0, 8'hff);
    wait_drain();

    // Outside both windows, and register index 3
    test_name = "decode_error";
    send_req(1'b0, 32'h0000_1000, '0, 8'hff);
    send_req(1'b1, L2 + `SOC_DRAM_LEN, 64'hbad0_bad0_bad0_bad0, 8'hff);
    send_req(1'b1, REG + 32'h18, 64'hbad1_bad1_bad1_bad1, 8'hff);
    send_req(1'b0, REG + 32'h18, '0, 8'hff);
    send_req(1'b0, REG - 32'h8, '0, 8'hff);
    send_req(1'b1, REG + `SOC_CTRL_LEN, 64'hbad2_bad2_bad2_bad2, 8'hff);
    test_name = "error_no_side_effect";
    send_req(1'b0, REG + 32'h10, '0, 8'hff);
    send_req(1'b0, REG + 32'h00, '0, 8'hff);
    send_req(1'b0, L2 + 32'h000, '0, 8'hff);
    wait_drain();

    test_name = "random_mix";
    stall_en  = 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      kind  = $urandom % 10;
      we    = 1'($urandom % 2);
      wdata = {$urandom, $urandom};
      strb  = 8'($urandom);
      if (kind < 5) begin
        word = 8'($urandom);
        // First write to a word covers all bytes
        if (!l2_written[word]) begin
          we   = 1'b1;
          strb = 8'hff;
        end
        l2_written[word] = 1'b1;
        addr = L2 + {21'd0, word, 3'd0};
      end else if (kind < 8) begin
        addr = REG + {20'd0, 9'($urandom % 5), 3'd0};
      end else begin
        addr = {4'h4, 28'($urandom)};
      end
      if ($urandom % 4 == 0) begin
        idle_cycles(1 + $urandom % 3);
      end
      send_req(we, addr, wdata, strb);
    end
    wait_drain();
    stall_en = 1'b0;
    check_value("random_mix exit_o", regs_m[`SOC_REG_EXIT], exit_w);
    check_value("random_mix hw_cnt_en_o", regs_m[`SOC_REG_CNT_EN], cnt_en_w);

    $display("Run complete, %0d check errors, %0d response errors", chk_errors, rsp_errors);
    if (chk_errors == 0 && rsp_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
